//--- dsp_top.f
+incdir+.
dsp_pkg.sv
shot_sequencer.sv
baseband_select.sv
gated_accumulator.sv
accbuf_writer.sv
dsp_top.sv
dsp_tb.sv

//--- dsp_tb_table.svh
// ====================
// dsp testbench table
// one row per test, stimulus and expected values
// ====================
`ifndef DSP_TB_TABLE_SVH
`define DSP_TB_TABLE_SVH

// name, nshot, starts, adc lanes, kept dac lanes, sel, gate length
// then totals per channel, write address, meas bits
test_row_t rows [8] = '{
	'{"one_shot_adc", 1, 1, '{10, 20, 30, 40}, '{1, 2, 3, 4}, 0, 5,
		'{500, 500}, 0, 2'b00},
	'{"three_shot_neg", 3, 3, '{-100, 50, -25, 5}, '{1, 2, 3, 4}, 0, 7,
		'{-490, -490}, 1, 2'b11},
	'{"dac_pair_lo", 2, 2, '{1, 1, 1, 1}, '{100, 200, 300, 400}, 1, 4,
		'{4000, 4032}, 2, 2'b00},
	'{"dac_pair_hi", 4, 4, '{1, 1, 1, 1}, '{-500, 100, -20, 7}, 2, 3,
		'{-1227, -1203}, 3, 2'b11},
	'{"free_run", 0, 6, '{1000, -2000, 3000, -4000}, '{0, 0, 0, 0}, 0, 2,
		'{-4000, -4000}, 4, 2'b11},
	'{"one_shot_after_rst", 1, 1, '{7, 7, 7, 7}, '{0, 0, 0, 0}, 0, 1,
		'{28, 28}, 0, 2'b00},
	'{"five_shots_max", 5, 5, '{32767, 32767, 32767, 32767}, '{0, 0, 0, 0}, 0, 10,
		'{1310680, 1310680}, 1, 2'b00},
	'{"dac_mixed", 2, 2, '{5, 5, 5, 5}, '{-1, -2, -3, -4}, 1, 6,
		'{-60, -12}, 2, 2'b11}
};

`endif

//--- dsp_tb.sv
// ====================
// dsp testbench
// processor core models, shot runs and readout windows
// ====================
`default_nettype none

module dsp_tb import dsp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 2000;

	typedef struct {
		string name;
		int nshot;
		// proc_start pulses to wait for
		int starts;
		int adc [ADC_LANES];
		// values of the kept dac lanes
		int dac [ADC_LANES];
		int sel;
		int gate_len;
		int exp_total [NDLO];
		int exp_addr;
		logic [NDLO-1:0] exp_meas;
	} test_row_t;

	logic dspif = 1'b0;
	logic rst_n;
	logic stb_start;
	logic acc_reset;
	logic proc_reset;
	logic proc_start;
	shot_t nshot;
	logic [NPROC-1:0] proc_done;
	logic [NPROC-1:0] elem_idle;
	seq_status_t status;
	adc_word_t adc;
	dac_word_t dac [NDAC];
	bb_sel_t mix_sel [NDLO];
	logic [NDLO-1:0] gate;
	logic [NDLO-1:0] meas;
	logic [NDLO-1:0] meas_valid;
	accbuf_wr_t accbuf_wr [NDLO];
	integer seed = 32'h89993187;
	int start_count = 0;
	int done_count = 0;
	int done_wait [NPROC];
	int idle_wait [NPROC];

	`include "dsp_tb_table.svh"

	dsp_top u_dut (.*);

	always #4 dspif = ~dspif;

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic value_error(input string test, input string what,
			input int exp, input int act);
		fail_with($sformatf("** Error %s: %s expected %0d, actual %0d", test, what, exp, act));
	endtask

	task automatic tick();
		@(posedge dspif);
		#1;
	endtask

	// pulse counters sampled mid cycle
	always @(negedge dspif) begin
		if (proc_start)
			start_count++;
		if (status.done)
			done_count++;
	end

	// core models raise done 3 to 10 cycles after start and idle a few later
	always @(posedge dspif) begin
		#1;
		for (int i = 0; i < NPROC; i++) begin
			if (proc_start) begin
				assert (!proc_reset)
					else fail_with("a core saw proc_start while proc_reset was high");
				proc_done[i] = 1'b0;
				elem_idle[i] = 1'b0;
				done_wait[i] = 3 + ($random(seed) & 7);
			end else if (done_wait[i] > 0) begin
				done_wait[i]--;
				if (done_wait[i] == 0) begin
					proc_done[i] = 1'b1;
					idle_wait[i] = 2 + ($random(seed) & 3);
				end
			end else if (idle_wait[i] > 0) begin
				idle_wait[i]--;
				if (idle_wait[i] == 0)
					elem_idle[i] = 1'b1;
			end
			// processor reset drops done
			if (proc_reset)
				proc_done[i] = 1'b0;
		end
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8)
			tick();
		rst_n = 1'b1;
		assert (proc_reset) else fail_with("proc_reset is low after reset");
		assert (!proc_start && !status.done)
			else fail_with("a sequencer strobe is high after reset");
		assert (!status.procdone) else fail_with("status.procdone is high after reset");
		assert (!accbuf_wr[0].we && !accbuf_wr[1].we)
			else fail_with("a buffer write is high after reset");
		assert (meas_valid == '0) else fail_with("meas_valid is high after reset");
	endtask

	task automatic set_inputs(input int lanes [ADC_LANES], input int kept [ADC_LANES],
			input int sel);
		for (int j = 0; j < ADC_LANES; j++)
			adc[j] = LANE_W'(lanes[j]);
		// kept lanes offset by the dac index and the rest filled with a constant
		for (int d = 0; d < NDAC; d++) begin
			for (int k = 0; k < DAC_LANES; k++)
				dac[d][k] = (k % UNDERSAMPLE == 0) ?
					LANE_W'(kept[k / UNDERSAMPLE] + d) : 16'h7f00;
		end
		for (int c = 0; c < NDLO; c++)
			mix_sel[c] = bb_sel_t'(sel);
		// bb is two cycles behind
		repeat (3)
			tick();
	endtask

	task automatic run_window(input string name, input int len, input int exp_total [NDLO],
			input int exp_addr, input logic [NDLO-1:0] exp_meas);
		int n;
		gate = '1;
		repeat (len)
			tick();
		gate = '0;
		for (n = 0; n < TIMEOUT && !accbuf_wr[0].we; n++)
			tick();
		assert (accbuf_wr[0].we) else fail_with("timeout, no accumulation buffer write came");
		for (int c = 0; c < NDLO; c++) begin
			assert (accbuf_wr[c].we) else fail_with("the channels wrote in different cycles");
			assert (accbuf_wr[c].data == exp_total[c])
				else value_error(name, "total", exp_total[c], accbuf_wr[c].data);
			assert (accbuf_wr[c].addr == exp_addr)
				else value_error(name, "address", exp_addr, accbuf_wr[c].addr);
		end
		for (n = 0; n < TIMEOUT && !meas_valid[0]; n++)
			tick();
		assert (meas_valid[0]) else fail_with("timeout, meas_valid never came");
		assert (meas_valid == '1)
			else fail_with("the channels raised meas_valid in different cycles");
		assert (meas == exp_meas) else value_error(name, "meas", exp_meas, meas);
	endtask

	task automatic run_shots(input test_row_t row);
		int n;
		int starts0;
		int dones0;
		int exp_count;
		exp_count = (row.nshot >= 2) ? row.nshot - 2 : 0;
		nshot = shot_t'(row.nshot);
		tick();
		starts0 = start_count;
		dones0 = done_count;
		stb_start = 1'b1;
		tick();
		stb_start = 1'b0;
		if (row.nshot == 0) begin
			for (n = 0; n < TIMEOUT && start_count - starts0 < row.starts; n++)
				tick();
			assert (start_count - starts0 >= row.starts)
				else fail_with("timeout, the free run stopped starting shots");
			assert (done_count == dones0) else fail_with("status.done came during a free run");
			apply_reset();
		end else begin
			for (n = 0; n < TIMEOUT && !status.done; n++)
				tick();
			assert (status.done) else fail_with("timeout, status.done never came");
			repeat (2)
				tick();
			assert (start_count - starts0 == row.nshot)
				else value_error(row.name, "proc_start pulses", row.nshot, start_count - starts0);
			assert (done_count - dones0 == 1)
				else value_error(row.name, "done pulses", 1, done_count - dones0);
			assert (status.shot_count == exp_count)
				else value_error(row.name, "shot_count", exp_count, status.shot_count);
			assert (status.procdone)
				else value_error(row.name, "procdone", 1, status.procdone);
		end
	endtask

	initial begin
		int sweep_lanes [ADC_LANES] = '{1, 2, 3, 4};
		int sweep_total [NDLO] = '{10, 10};
		rst_n = 1'b0;
		stb_start = 1'b0;
		acc_reset = 1'b0;
		nshot = '0;
		adc = '0;
		gate = '0;
		proc_done = '0;
		elem_idle = '1;
		for (int d = 0; d < NDAC; d++)
			dac[d] = '0;
		for (int c = 0; c < NDLO; c++)
			mix_sel[c] = '0;
		apply_reset();
		foreach (rows[r]) begin
			set_inputs(rows[r].adc, rows[r].dac, rows[r].sel);
			run_window(rows[r].name, rows[r].gate_len, rows[r].exp_total, rows[r].exp_addr,
				rows[r].exp_meas);
			run_shots(rows[r]);
		end
		// address walk up to the last entry and back
		set_inputs(sweep_lanes, sweep_lanes, 0);
		acc_reset = 1'b1;
		tick();
		acc_reset = 1'b0;
		for (int k = 0; k < 18; k++)
			run_window("addr_lock", 1, sweep_total, (k < 15) ? k : 15, 2'b00);
		acc_reset = 1'b1;
		tick();
		acc_reset = 1'b0;
		run_window("addr_clear", 1, sweep_total, 0, 2'b00);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dsp_top.sv
// ====================
// dsp top
// shot sequencer plus the readout channels
// ====================
`default_nettype none

module dsp_top import dsp_pkg::*; (
	input logic dspif,
	input logic rst_n,
	// sequencer
	input logic stb_start,
	input shot_t nshot,
	input logic [NPROC-1:0] proc_done,
	input logic [NPROC-1:0] elem_idle,
	output logic proc_reset,
	output logic proc_start,
	output seq_status_t status,
	// readout
	input adc_word_t adc,
	input dac_word_t dac [NDAC],
	input bb_sel_t mix_sel [NDLO],
	input logic [NDLO-1:0] gate,
	input logic acc_reset,
	output accbuf_wr_t accbuf_wr [NDLO],
	output logic [NDLO-1:0] meas,
	output logic [NDLO-1:0] meas_valid
);

	adc_word_t bb [NDLO];

	shot_sequencer u_seq (
		.dspif(dspif),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.elem_idle(elem_idle),
		.proc_reset(proc_reset),
		.proc_start(proc_start),
		.status(status)
	);

	baseband_select u_bbsel (
		.dspif(dspif),
		.adc(adc),
		.dac(dac),
		.mix_sel(mix_sel),
		.bb(bb)
	);

	// one integrator and buffer port per channel
	for (genvar c = 0; c < NDLO; c++) begin : g_rdlo
		acc_t result;
		logic result_stb;

		gated_accumulator u_acc (
			.dspif(dspif),
			.rst_n(rst_n),
			.bb(bb[c]),
			.gate(gate[c]),
			.result(result),
			.result_stb(result_stb)
		);

		accbuf_writer u_wr (
			.dspif(dspif),
			.rst_n(rst_n),
			.result(result),
			.result_stb(result_stb),
			.acc_reset(acc_reset),
			.accbuf_wr(accbuf_wr[c]),
			.meas(meas[c]),
			.meas_valid(meas_valid[c])
		);
	end

endmodule

`default_nettype wire

//--- accbuf_writer.sv
// ====================
// accbuf writer
// write port of the accumulation buffer
// address locks at the last entry, plus threshold bit
// ====================
`default_nettype none

module accbuf_writer import dsp_pkg::*; (
	input logic dspif,
	input logic rst_n,
	input acc_t result,
	input logic result_stb,
	input logic acc_reset,
	output accbuf_wr_t accbuf_wr,
	output logic meas,
	output logic meas_valid
);

	logic acc_reset_r;
	logic we_r;
	accbuf_addr_t addr_r;
	acc_t data_r;
	// buffer full, stop advancing
	logic locklast;

	assign locklast = &addr_r;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			acc_reset_r <= 1'b0;
			we_r <= 1'b0;
			addr_r <= '0;
			meas_valid <= 1'b0;
		end else begin
			acc_reset_r <= acc_reset;
			we_r <= result_stb;
			// step after each write
			addr_r <= acc_reset_r ? '0 : addr_r + accbuf_addr_t'(we_r && !locklast);
			meas_valid <= we_r;
		end
	end

	always_ff @(posedge dspif) begin
		data_r <= result;
		// threshold on the x axis, negative is one
		meas <= data_r[ACC_W-1];
	end

	assign accbuf_wr = '{we: we_r, addr: addr_r, data: data_r};

endmodule

`default_nettype wire

//--- gated_accumulator.sv
// ====================
// gated accumulator
// sums all lanes while the gate is high
// total comes out when the gate falls
// ====================
`default_nettype none

module gated_accumulator import dsp_pkg::*; (
	input logic dspif,
	input logic rst_n,
	input adc_word_t bb,
	input logic gate,
	output acc_t result,
	output logic result_stb
);

	acc_t lane_sum;
	acc_t total;
	logic gate_d;

	// sign-extended lane sum of this cycle
	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < ADC_LANES; i++) begin
			lane_sum = lane_sum + acc_t'($signed(bb[i]));
		end
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			gate_d <= 1'b0;
			total <= '0;
			result_stb <= 1'b0;
		end else begin
			gate_d <= gate;
			// falling gate ends the window
			result_stb <= gate_d && !gate;
			if (gate) begin
				total <= total + lane_sum;
			end else if (gate_d) begin
				total <= '0;
			end
		end
	end

	// payload captured with the strobe
	always_ff @(posedge dspif) begin
		if (gate_d && !gate) begin
			result <= total;
		end
	end

endmodule

`default_nettype wire

//--- baseband_select.sv
// ====================
// baseband select
// registers the adc word, undersamples the dac words
// and picks one baseband stream per readout channel
// ====================
`default_nettype none

module baseband_select import dsp_pkg::*; (
	input logic dspif,
	input adc_word_t adc,
	input dac_word_t dac [NDAC],
	input bb_sel_t mix_sel [NDLO],
	output adc_word_t bb [NDLO]
);

	adc_word_t adc_r;
	// one adc-rate word per dac
	adc_word_t dac_us [NDAC];

	always_ff @(posedge dspif) begin
		adc_r <= adc;
	end

	// keep every UNDERSAMPLE-th dac lane
	for (genvar d = 0; d < NDAC; d++) begin : g_dac
		for (genvar j = 0; j < ADC_LANES; j++) begin : g_lane
			always_ff @(posedge dspif) begin
				dac_us[d][j] <= dac[d][j*UNDERSAMPLE];
			end
		end
	end

	// channel c owns dac 2c and 2c+1
	for (genvar c = 0; c < NDLO; c++) begin : g_chan
		always_ff @(posedge dspif) begin
			case (mix_sel[c])
				2'd0: bb[c] <= adc_r;
				2'd1: bb[c] <= dac_us[2*c];
				2'd2: bb[c] <= dac_us[2*c+1];
				// source 3 holds
				default: bb[c] <= bb[c];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- shot_sequencer.sv
// ====================
// shot sequencer
// runs nshot shots with a processor reset and start per shot
// nshot of zero runs until reset
// ====================
`default_nettype none

module shot_sequencer import dsp_pkg::*; (
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input shot_t nshot,
	input logic [NPROC-1:0] proc_done,
	input logic [NPROC-1:0] elem_idle,
	output logic proc_reset,
	output logic proc_start,
	output seq_status_t status
);

	seq_state_e state;
	seq_state_e nextstate;

	// all cores finished / all elements quiet, one cycle late
	logic procdone_r;
	logic idle_r;

	shot_t nshot_r;
	shot_t shot_cnt;
	shot_t next_cnt;
	// registered decision for MORESHOT
	logic go_on;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= nextstate;
		end
	end

	always_comb begin
		nextstate = IDLE;
		case (state)
			IDLE: nextstate = stb_start ? START : IDLE;
			START: nextstate = PROCRUN;
			PROCRUN: nextstate = procdone_r ? ELEMBUSY : PROCRUN;
			ELEMBUSY: nextstate = idle_r ? MORESHOT : ELEMBUSY;
			MORESHOT: nextstate = go_on ? SHOTADD : DONE;
			SHOTADD: nextstate = START;
			DONE: nextstate = IDLE;
			default: nextstate = IDLE;
		endcase
	end

	// shot counting pipeline
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			procdone_r <= 1'b0;
			idle_r <= 1'b0;
			next_cnt <= '0;
			go_on <= 1'b0;
		end else begin
			procdone_r <= &proc_done;
			idle_r <= &elem_idle;
			next_cnt <= shot_cnt + 1'b1;
			// more shots left, or free running
			go_on <= (next_cnt != nshot_r) || (nshot_r == '0);
		end
	end

	// outputs follow the state being entered
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			shot_cnt <= '0;
			nshot_r <= nshot;
			proc_reset <= 1'b1;
			proc_start <= 1'b0;
			status.done <= 1'b0;
			status.shot_count <= '0;
		end else begin
			proc_reset <= !(nextstate == START || nextstate == PROCRUN);
			proc_start <= (nextstate == START);
			status.done <= (nextstate == DONE);
			case (nextstate)
				IDLE: begin
					shot_cnt <= '0;
					nshot_r <= nshot;
				end
				SHOTADD: begin
					shot_cnt <= next_cnt;
					// report the shot just finished
					status.shot_count <= shot_cnt;
				end
				DONE: begin
					shot_cnt <= '0;
				end
				default: begin
					shot_cnt <= shot_cnt;
				end
			endcase
		end
	end

	// sticky until the next start
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			status.procdone <= 1'b0;
		end else if (procdone_r) begin
			status.procdone <= 1'b1;
		end else if (proc_start) begin
			status.procdone <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- dsp_pkg.sv
// ====================
// dsp package
// widths, counts, types and sequencer states
// shared by the readout front end and the shot sequencer
// ====================
`default_nettype none

package dsp_pkg;

	// counts
	localparam int NPROC = 2;
	localparam int NDLO = 2;
	localparam int NDAC = 4;

	// sample lanes
	localparam int LANE_W = 16;
	localparam int ADC_LANES = 4;
	localparam int DAC_LANES = 16;
	// dac lanes per adc lane
	localparam int UNDERSAMPLE = 4;

	// results and counters
	localparam int ACC_W = 32;
	localparam int ACCBUF_ADDR_W = 4;
	localparam int SHOT_W = 16;

	// baseband word, lane 0 in the low bits
	typedef logic signed [ADC_LANES-1:0][LANE_W-1:0] adc_word_t;
	typedef logic [DAC_LANES-1:0][LANE_W-1:0] dac_word_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [ACCBUF_ADDR_W-1:0] accbuf_addr_t;
	typedef logic [SHOT_W-1:0] shot_t;
	// 0 adc, 1/2 dac pair, 3 hold
	typedef logic [1:0] bb_sel_t;

	// gray-ish walk through a shot
	typedef enum logic [3:0] {
		IDLE = 4'b0000,
		START = 4'b0001,
		PROCRUN = 4'b0011,
		ELEMBUSY = 4'b0010,
		MORESHOT = 4'b0110,
		SHOTADD = 4'b0111,
		DONE = 4'b0101
	} seq_state_e;

	typedef struct packed {
		logic done;
		logic procdone;
		shot_t shot_count;
	} seq_status_t;

	typedef struct packed {
		logic we;
		accbuf_addr_t addr;
		acc_t data;
	} accbuf_wr_t;

endpackage

`default_nettype wire
